// File: design/mem_xfer_defines.svh
// Memory transfer engine widths
`ifndef MEM_XFER_DEFINES_SVH
`define MEM_XFER_DEFINES_SVH

//----------------------------------------
// Bus and line widths.
//----------------------------------------

// APB address width.
`define MX_ADDR_BITS   32

// APB data width, one word per beat.
`define MX_WORD_BITS   32

// Cache line width.
`define MX_BLOCK_BITS  512

// Uncached byte width and strobe width.
`define MX_BYTE_BITS   8
`define MX_STRB_BITS   4

//----------------------------------------
// Beat sequencing.
//----------------------------------------

// Words per line and width of the beat index.
`define MX_BEATS       16
`define MX_BEAT_BITS   4

// Address bits below the line boundary (64 bytes).
`define MX_OFFSET_BITS 6

`endif

// File: design/mem_xfer_pkg.sv
// Memory transfer engine types
package mem_xfer_pkg;

    //----------------------------------------
    // Requested operations.
    //----------------------------------------

    // Bit 1 marks an uncached byte access, bit 0 a write.
    typedef enum logic [1:0] {
        OP_BLOCK_READ  = 2'b00,
        OP_BLOCK_WRITE = 2'b01,
        OP_BYTE_READ   = 2'b10,
        OP_BYTE_WRITE  = 2'b11
    } xfer_op_e;

    //----------------------------------------
    // Controller states.
    //----------------------------------------

    // IDLE waits for a request.
    // SETUP is the APB setup phase of a beat.
    // ACCESS holds until pready.
    // FINISH signals completion.
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        SETUP  = 2'b01,
        ACCESS = 2'b10,
        FINISH = 2'b11
    } xfer_state_e;

endpackage

// File: design/xfer_ctrl_fsm.sv
// Transfer control state machine
`timescale 1ns/1ps

module xfer_ctrl_fsm
    import mem_xfer_pkg::*;
(
    input  logic        clk,
    input  logic        i_arst_n,
    input  logic        i_req_valid,
    input  xfer_op_e    i_req_op,
    input  logic        i_beat_done,
    input  logic        i_last,
    input  logic        i_pslverr,
    output logic        o_req_ready,
    output xfer_state_e o_state,
    output logic        o_beat_start,
    output logic        o_cnt_clear,
    output logic        o_cnt_inc,
    output logic        o_done,
    output logic        o_is_write,
    output logic        o_is_block,
    output logic        o_err
);

    xfer_state_e state_q;
    xfer_state_e state_d;
    xfer_op_e    op_q;
    xfer_op_e    cur_op;
    logic        accept;
    logic        beat_last;
    logic        err_q;
    logic        done_q;

    assign o_req_ready = (state_q == IDLE);
    assign accept      = i_req_valid & o_req_ready;

    // The incoming op steers the first beat while still in IDLE.
    assign cur_op     = (state_q == IDLE) ? i_req_op : op_q;
    assign o_is_block = (cur_op == OP_BLOCK_READ) || (cur_op == OP_BLOCK_WRITE);
    assign o_is_write = (cur_op == OP_BLOCK_WRITE) || (cur_op == OP_BYTE_WRITE);

    // Byte accesses are a single beat.
    assign beat_last = ~o_is_block | i_last;

    //----------------------------------------
    // Beat steering.
    //----------------------------------------
    assign o_cnt_clear  = accept;
    assign o_cnt_inc    = i_beat_done & ~beat_last;
    assign o_beat_start = accept | (i_beat_done & ~beat_last);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (accept) state_d = SETUP;
            SETUP:   state_d = ACCESS;
            ACCESS: begin
                if (i_beat_done) begin
                    state_d = beat_last ? FINISH : SETUP;
                end
            end
            FINISH:  state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= IDLE;
            op_q    <= OP_BLOCK_READ;
            err_q   <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= i_beat_done & beat_last;
            if (accept) begin
                op_q  <= i_req_op;
                err_q <= 1'b0;
            end else if (i_beat_done && i_pslverr) begin
                err_q <= 1'b1;   // sticky over the whole line
            end
        end
    end

    assign o_state = state_q;
    assign o_done  = done_q;
    assign o_err   = err_q;

    // Completion pulse only in the FINISH cycle.
    a_done_in_finish: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        o_done |-> (state_q == FINISH)
    );

endmodule

// File: design/beat_counter.sv
// Line beat counter
`timescale 1ns/1ps
`include "mem_xfer_defines.svh"

module beat_counter (
    input  logic                     clk,
    input  logic                     i_arst_n,
    input  logic                     i_clear,
    input  logic                     i_inc,
    output logic [`MX_BEAT_BITS-1:0] o_count,
    output logic                     o_last
);

    logic [`MX_BEAT_BITS-1:0] count_q;

    //----------------------------------------
    // Word index within the line.
    //----------------------------------------
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            count_q <= '0;
        end else if (i_clear) begin
            count_q <= '0;
        end else if (i_inc) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign o_count = count_q;

    // Final word of the line.
    assign o_last = (count_q == `MX_BEAT_BITS'(`MX_BEATS - 1));

    // Controller must stop at the last beat, never wrap.
    a_no_wrap: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        i_inc |-> !o_last
    );

endmodule

// File: design/block_buffer.sv
// Cache line and byte lane buffer
`timescale 1ns/1ps
`include "mem_xfer_defines.svh"

module block_buffer (
    input  logic                      clk,
    input  logic                      i_arst_n,
    input  logic                      i_load,
    input  logic [`MX_BLOCK_BITS-1:0] i_wblock,
    input  logic [`MX_BYTE_BITS-1:0]  i_wbyte,
    input  logic [1:0]                i_addr_lane,
    input  logic                      i_is_block,
    input  logic                      i_capture,
    input  logic [`MX_WORD_BITS-1:0]  i_prdata,
    output logic [`MX_WORD_BITS-1:0]  o_wword,
    output logic [`MX_BLOCK_BITS-1:0] o_rblock,
    output logic [`MX_BYTE_BITS-1:0]  o_rbyte
);

    logic [`MX_BLOCK_BITS-1:0] line_q;
    logic [1:0]                lane_q;
    logic [`MX_BYTE_BITS-1:0]  rbyte_q;
    logic [`MX_BYTE_BITS-1:0]  lane_byte;

    //----------------------------------------
    // Line shift register.
    //----------------------------------------

    // Write words leave at the bottom, read words enter at the top.
    always_ff @(posedge clk) begin
        if (i_load && i_is_block) begin
            line_q <= i_wblock;
        end else if (i_capture && i_is_block) begin
            line_q <= {i_prdata, line_q[`MX_BLOCK_BITS-1:`MX_WORD_BITS]};
        end
    end

    // Word for the next beat, looked up one shift ahead.
    always_comb begin
        if (i_load) begin
            if (i_is_block) begin
                o_wword = i_wblock[`MX_WORD_BITS-1:0];
            end else begin
                o_wword = {(`MX_WORD_BITS / `MX_BYTE_BITS){i_wbyte}};
            end
        end else begin
            o_wword = line_q[2*`MX_WORD_BITS-1:`MX_WORD_BITS];
        end
    end

    //----------------------------------------
    // Uncached byte lane.
    //----------------------------------------
    assign lane_byte = i_prdata[{lane_q, 3'b000} +: `MX_BYTE_BITS];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            lane_q  <= 2'b00;
            rbyte_q <= '0;
        end else begin
            if (i_load) begin
                lane_q <= i_addr_lane;
            end
            if (i_capture && !i_is_block) begin
                rbyte_q <= lane_byte;
            end
        end
    end

    assign o_rblock = line_q;
    assign o_rbyte  = rbyte_q;

endmodule

// File: design/apb_requester.sv
// APB master phase driver
`timescale 1ns/1ps
`include "mem_xfer_defines.svh"

module apb_requester
    import mem_xfer_pkg::*;
(
    input  logic                     clk,
    input  logic                     i_arst_n,
    input  xfer_state_e              i_state,
    input  logic                     i_beat_start,
    input  logic [`MX_ADDR_BITS-1:0] i_base_addr,
    input  logic [`MX_BEAT_BITS-1:0] i_count,
    input  logic                     i_is_block,
    input  logic                     i_is_write,
    input  logic [`MX_WORD_BITS-1:0] i_wword,
    input  logic                     i_pready,
    input  logic [`MX_WORD_BITS-1:0] i_prdata,
    output logic                     o_psel,
    output logic                     o_penable,
    output logic                     o_pwrite,
    output logic [`MX_ADDR_BITS-1:0] o_paddr,
    output logic [`MX_WORD_BITS-1:0] o_pwdata,
    output logic [`MX_STRB_BITS-1:0] o_pstrb,
    output logic                     o_beat_done,
    output logic [`MX_WORD_BITS-1:0] o_rdata
);

    logic                     first_beat;
    logic [`MX_ADDR_BITS-1:0] start_base;
    logic [`MX_ADDR_BITS-1:0] base_q;
    logic [`MX_BEAT_BITS-1:0] next_idx;
    logic [`MX_ADDR_BITS-1:0] beat_addr;
    logic [`MX_STRB_BITS-1:0] strb_d;

    //----------------------------------------
    // Beat address and strobe.
    //----------------------------------------
    assign first_beat = (i_state == IDLE);

    // Lines are 64-byte aligned.
    assign start_base = i_is_block ?
        {i_base_addr[`MX_ADDR_BITS-1:`MX_OFFSET_BITS], {`MX_OFFSET_BITS{1'b0}}} :
        i_base_addr;

    // Later beats start while the counter still holds the previous index.
    assign next_idx  = first_beat ? '0 : i_count + 1'b1;
    assign beat_addr = (first_beat ? start_base : base_q) +
        {{(`MX_ADDR_BITS-`MX_BEAT_BITS-2){1'b0}}, next_idx, 2'b00};

    always_comb begin
        if (!i_is_write) begin
            strb_d = '0;
        end else if (i_is_block) begin
            strb_d = '1;
        end else begin
            strb_d = {{(`MX_STRB_BITS-1){1'b0}}, 1'b1} << i_base_addr[1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (i_beat_start) begin
            o_paddr  <= beat_addr;
            o_pwdata <= i_wword;
            if (first_beat) begin
                base_q <= start_base;
            end
        end
    end

    //----------------------------------------
    // Phase control.
    //----------------------------------------
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_psel    <= 1'b0;
            o_penable <= 1'b0;
            o_pwrite  <= 1'b0;
            o_pstrb   <= '0;
        end else begin
            if (i_beat_start && first_beat) begin
                o_pwrite <= i_is_write;
                o_pstrb  <= strb_d;
            end
            if (i_beat_start) begin
                o_psel    <= 1'b1;
                o_penable <= 1'b0;
            end else if (o_psel && !o_penable) begin
                o_penable <= 1'b1;
            end else if (o_penable && i_pready) begin
                o_psel    <= 1'b0;
                o_penable <= 1'b0;
            end
        end
    end

    assign o_beat_done = (i_state == ACCESS) & i_pready;
    assign o_rdata     = i_prdata & {`MX_WORD_BITS{o_beat_done}};

    a_penable_psel: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        o_penable |-> o_psel
    );

    a_addr_stable: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        (o_psel && !i_pready) |=> $stable(o_paddr)
    );

    // Bus phases track the controller state.
    a_psel_state: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        o_psel == ((i_state == SETUP) || (i_state == ACCESS))
    );

endmodule

// File: design/mem_xfer_top.sv
// Cache line transfer engine
`timescale 1ns/1ps
`include "mem_xfer_defines.svh"

module mem_xfer_top
    import mem_xfer_pkg::*;
(
    input  logic                      clk,
    input  logic                      i_arst_n,
    input  logic                      i_req_valid,
    input  xfer_op_e                  i_req_op,
    input  logic [`MX_ADDR_BITS-1:0]  i_req_addr,
    input  logic [`MX_BLOCK_BITS-1:0] i_req_wblock,
    input  logic [`MX_BYTE_BITS-1:0]  i_req_wbyte,
    input  logic                      i_pready,
    input  logic [`MX_WORD_BITS-1:0]  i_prdata,
    input  logic                      i_pslverr,
    output logic                      o_req_ready,
    output logic                      o_done,
    output logic                      o_err,
    output logic [`MX_BLOCK_BITS-1:0] o_rblock,
    output logic [`MX_BYTE_BITS-1:0]  o_rbyte,
    output logic                      o_psel,
    output logic                      o_penable,
    output logic                      o_pwrite,
    output logic [`MX_ADDR_BITS-1:0]  o_paddr,
    output logic [`MX_WORD_BITS-1:0]  o_pwdata,
    output logic [`MX_STRB_BITS-1:0]  o_pstrb
);

    //----------------------------------------
    // Internal nets.
    //----------------------------------------
    xfer_state_e              s_state;
    logic                     s_beat_start;
    logic                     s_cnt_clear;
    logic                     s_cnt_inc;
    logic                     s_is_write;
    logic                     s_is_block;
    logic                     s_beat_done;
    logic                     s_last;
    logic [`MX_BEAT_BITS-1:0] s_count;
    logic [`MX_WORD_BITS-1:0] s_wword;
    logic [`MX_WORD_BITS-1:0] s_rdata;

    xfer_ctrl_fsm CTRL (
        .clk          ( clk          ),
        .i_arst_n     ( i_arst_n     ),
        .i_req_valid  ( i_req_valid  ),
        .i_req_op     ( i_req_op     ),
        .i_beat_done  ( s_beat_done  ),
        .i_last       ( s_last       ),
        .i_pslverr    ( i_pslverr    ),
        .o_req_ready  ( o_req_ready  ),
        .o_state      ( s_state      ),
        .o_beat_start ( s_beat_start ),
        .o_cnt_clear  ( s_cnt_clear  ),
        .o_cnt_inc    ( s_cnt_inc    ),
        .o_done       ( o_done       ),
        .o_is_write   ( s_is_write   ),
        .o_is_block   ( s_is_block   ),
        .o_err        ( o_err        )
    );

    beat_counter CNT (
        .clk      ( clk         ),
        .i_arst_n ( i_arst_n    ),
        .i_clear  ( s_cnt_clear ),
        .i_inc    ( s_cnt_inc   ),
        .o_count  ( s_count     ),
        .o_last   ( s_last      )
    );

    // Loads on the accept cycle, signalled by the counter clear.
    block_buffer BUF (
        .clk         ( clk              ),
        .i_arst_n    ( i_arst_n         ),
        .i_load      ( s_cnt_clear      ),
        .i_wblock    ( i_req_wblock     ),
        .i_wbyte     ( i_req_wbyte      ),
        .i_addr_lane ( i_req_addr[1:0]  ),
        .i_is_block  ( s_is_block       ),
        .i_capture   ( s_beat_done      ),
        .i_prdata    ( s_rdata          ),
        .o_wword     ( s_wword          ),
        .o_rblock    ( o_rblock         ),
        .o_rbyte     ( o_rbyte          )
    );

    apb_requester APB (
        .clk          ( clk          ),
        .i_arst_n     ( i_arst_n     ),
        .i_state      ( s_state      ),
        .i_beat_start ( s_beat_start ),
        .i_base_addr  ( i_req_addr   ),
        .i_count      ( s_count      ),
        .i_is_block   ( s_is_block   ),
        .i_is_write   ( s_is_write   ),
        .i_wword      ( s_wword      ),
        .i_pready     ( i_pready     ),
        .i_prdata     ( i_prdata     ),
        .o_psel       ( o_psel       ),
        .o_penable    ( o_penable    ),
        .o_pwrite     ( o_pwrite     ),
        .o_paddr      ( o_paddr      ),
        .o_pwdata     ( o_pwdata     ),
        .o_pstrb      ( o_pstrb      ),
        .o_beat_done  ( s_beat_done  ),
        .o_rdata      ( s_rdata      )
    );

endmodule

// File: verification/tb_mem_xfer.sv
// Transfer engine testbench
`timescale 1ns/1ps
`include "mem_xfer_defines.svh"

module tb_mem_xfer;

    localparam logic [31:0] SEED     = 32'h3a40f5b5;
    localparam logic [31:0] FILL_KEY = 32'h5a5a0000;
    localparam logic [31:0] ERR_BASE = 32'hF000_0000;
    localparam int          TIMEOUT  = 200;

    logic                      clk;
    logic                      i_arst_n;
    logic                      i_req_valid;
    mem_xfer_pkg::xfer_op_e    i_req_op;
    logic [`MX_ADDR_BITS-1:0]  i_req_addr;
    logic [`MX_BLOCK_BITS-1:0] i_req_wblock;
    logic [`MX_BYTE_BITS-1:0]  i_req_wbyte;
    logic                      i_pready;
    logic [`MX_WORD_BITS-1:0]  i_prdata;
    logic                      i_pslverr;
    logic                      o_req_ready;
    logic                      o_done;
    logic                      o_err;
    logic [`MX_BLOCK_BITS-1:0] o_rblock;
    logic [`MX_BYTE_BITS-1:0]  o_rbyte;
    logic                      o_psel;
    logic                      o_penable;
    logic                      o_pwrite;
    logic [`MX_ADDR_BITS-1:0]  o_paddr;
    logic [`MX_WORD_BITS-1:0]  o_pwdata;
    logic [`MX_STRB_BITS-1:0]  o_pstrb;

    // Words written so far, keyed by word address.
    logic [31:0] mem [logic [31:0]];
    logic [31:0] rng_state;
    int          n_req;

    mem_xfer_top DUT (
        .clk          ( clk          ),
        .i_arst_n     ( i_arst_n     ),
        .i_req_valid  ( i_req_valid  ),
        .i_req_op     ( i_req_op     ),
        .i_req_addr   ( i_req_addr   ),
        .i_req_wblock ( i_req_wblock ),
        .i_req_wbyte  ( i_req_wbyte  ),
        .i_pready     ( i_pready     ),
        .i_prdata     ( i_prdata     ),
        .i_pslverr    ( i_pslverr    ),
        .o_req_ready  ( o_req_ready  ),
        .o_done       ( o_done       ),
        .o_err        ( o_err        ),
        .o_rblock     ( o_rblock     ),
        .o_rbyte      ( o_rbyte      ),
        .o_psel       ( o_psel       ),
        .o_penable    ( o_penable    ),
        .o_pwrite     ( o_pwrite     ),
        .o_paddr      ( o_paddr      ),
        .o_pwdata     ( o_pwdata     ),
        .o_pstrb      ( o_pstrb      )
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Untouched words hold their own address XOR the fill key.
    function automatic logic [31:0] read_word(input logic [31:0] addr);
        logic [31:0] wa;
        wa = {addr[31:2], 2'b00};
        if (mem.exists(wa)) begin
            return mem[wa];
        end
        return wa ^ FILL_KEY;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        stop_with_failure($sformatf("ERR t=%0t %s got %h expected %h",
                                    $time, name, got, exp));
    endtask

    //----------------------------------------
    // APB memory model.
    //----------------------------------------
    always @(posedge clk) begin : apb_model
        logic [31:0] word;
        rng_state = xorshift32(rng_state);
        i_pready <= (rng_state[1:0] != 2'b00);
        if (o_psel && o_penable && i_pready && o_pwrite) begin
            word = read_word(o_paddr);
            for (int b = 0; b < 4; b++) begin
                if (o_pstrb[b]) begin
                    word[8*b +: 8] = o_pwdata[8*b +: 8];
                end
            end
            mem[{o_paddr[31:2], 2'b00}] = word;
        end
        // Reads carry no byte strobes.
        if (o_psel && !o_pwrite) begin
            assert (o_pstrb == '0) else report_mismatch("o_pstrb", o_pstrb, 0);
        end
        // Read data and error follow the address of the current beat.
        if (o_psel) begin
            i_prdata  <= read_word(o_paddr);
            i_pslverr <= (o_paddr >= ERR_BASE);
        end
    end

    task automatic check_idle();
        assert (o_psel == 1'b0) else report_mismatch("o_psel", o_psel, 0);
        assert (o_penable == 1'b0) else report_mismatch("o_penable", o_penable, 0);
        assert (o_done == 1'b0) else report_mismatch("o_done", o_done, 0);
        assert (o_req_ready == 1'b1) else report_mismatch("o_req_ready", o_req_ready, 1);
        assert (o_err == 1'b0) else report_mismatch("o_err", o_err, 0);
    endtask

    //----------------------------------------
    // One request from the trace.
    //----------------------------------------
    task automatic run_request(input logic [1:0] op, input logic [31:0] addr,
                               input logic [31:0] wdata, input logic [31:0] exp_data,
                               input logic exp_err, input logic [31:0] pidx,
                               input logic [31:0] pval);
        logic [`MX_BLOCK_BITS-1:0] wline;
        logic [31:0]               exp_word;
        int                        cycles;
        // Line word k is the given value plus 4k.
        for (int k = 0; k < `MX_BEATS; k++) begin
            wline[32*k +: 32] = wdata + 32'(4 * k);
        end
        cycles = 0;
        @(posedge clk);
        while (!o_req_ready) begin
            cycles++;
            if (cycles >= TIMEOUT) begin
                stop_with_failure("Timed out waiting for the engine to become ready.");
            end
            @(posedge clk);
        end
        i_req_valid  <= 1'b1;
        i_req_op     <= mem_xfer_pkg::xfer_op_e'(op);
        i_req_addr   <= addr;
        i_req_wblock <= wline;
        i_req_wbyte  <= wdata[7:0];
        @(posedge clk);
        assert (o_req_ready) else stop_with_failure("The idle engine did not take a request.");
        i_req_valid <= 1'b0;
        cycles = 0;
        @(posedge clk);
        while (!o_done) begin
            cycles++;
            if (cycles >= TIMEOUT) begin
                stop_with_failure("Timed out waiting for the transfer to complete.");
            end
            @(posedge clk);
        end
        assert (o_err == exp_err) else report_mismatch("o_err", o_err, exp_err);
        if (op == 2'b00) begin
            for (int k = 0; k < `MX_BEATS; k++) begin
                exp_word = (pidx == k) ? pval : exp_data + 32'(4 * k);
                assert (o_rblock[32*k +: 32] == exp_word)
                else report_mismatch($sformatf("o_rblock word %0d", k),
                                     o_rblock[32*k +: 32], exp_word);
            end
        end else if (op == 2'b10) begin
            assert (o_rbyte == exp_data[7:0])
            else report_mismatch("o_rbyte", o_rbyte, exp_data[7:0]);
        end
    endtask

    initial begin
        int          fd;
        string       line;
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp_data;
        logic [31:0] exp_err;
        logic [31:0] pidx;
        logic [31:0] pval;
        clk          = 1'b0;
        i_arst_n     = 1'b0;
        i_req_valid  = 1'b0;
        i_req_op     = mem_xfer_pkg::OP_BLOCK_READ;
        i_req_addr   = '0;
        i_req_wblock = '0;
        i_req_wbyte  = '0;
        i_pready     = 1'b0;
        i_prdata     = '0;
        i_pslverr    = 1'b0;
        rng_state    = SEED;
        n_req        = 0;
        repeat (2) @(posedge clk);
        i_arst_n <= 1'b1;
        @(posedge clk);
        check_idle();
        fd = $fopen("verification/xfer_trace.txt", "r");
        if (fd == 0) begin
            stop_with_failure("Could not open the trace file.");
        end
        // Comment lines yield no fields and are skipped.
        while ($fgets(line, fd) != 0) begin
            if ($sscanf(line, "%h %h %h %h %h %h %h",
                        op, addr, wdata, exp_data, exp_err, pidx, pval) == 7) begin
                run_request(op[1:0], addr, wdata, exp_data, exp_err[0], pidx, pval);
                n_req++;
            end
        end
        $fclose(fd);
        if (n_req == 0) begin
            stop_with_failure("The trace file held no requests.");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

// File: verification/xfer_trace.txt
# op addr wdata expect err patch_idx patch_val, all hex; op 0..3 = line rd, line wr, byte rd, byte wr
# Line word k is value + 4k, except word patch_idx which holds patch_val (ff for none).
0 00001000 00000000 5a5a1000 0 ff 00000000
0 00002034 00000000 5a5a2000 0 ff 00000000
1 00003000 c0de0000 00000000 0 ff 00000000
0 00003000 00000000 c0de0000 0 ff 00000000
1 00004010 12345678 00000000 0 ff 00000000
0 0000403c 00000000 12345678 0 ff 00000000
3 00003006 000000a5 00000000 0 ff 00000000
2 00003006 00000000 000000a5 0 ff 00000000
2 00003007 00000000 000000c0 0 ff 00000000
2 00003004 00000000 00000004 0 ff 00000000
0 00003000 00000000 c0de0000 0 01 c0a50004
3 00005003 0000003c 00000000 0 ff 00000000
2 00005003 00000000 0000003c 0 ff 00000000
2 00005001 00000000 00000050 0 ff 00000000
0 00005000 00000000 5a5a5000 0 00 3c5a5000
0 f0000040 00000000 aa5a0040 1 ff 00000000
0 00001000 00000000 5a5a1000 0 ff 00000000
2 f0000102 00000000 0000005a 1 ff 00000000
2 00001002 00000000 0000005a 0 ff 00000000
1 f0000080 11110000 00000000 1 ff 00000000
3 f0000003 00000077 00000000 1 ff 00000000
3 00001001 00000099 00000000 0 ff 00000000
2 00001001 00000000 00000099 0 ff 00000000
0 00001000 00000000 5a5a1000 0 00 5a5a9900

// File: files.f
+incdir+design
design/mem_xfer_pkg.sv
design/xfer_ctrl_fsm.sv
design/beat_counter.sv
design/block_buffer.sv
design/apb_requester.sv
design/mem_xfer_top.sv
verification/tb_mem_xfer.sv

// File: Bender.yml
package:
  name: mem_xfer

sources:
  - include_dirs:
      - design
    files:
      - design/mem_xfer_pkg.sv
      - design/xfer_ctrl_fsm.sv
      - design/beat_counter.sv
      - design/block_buffer.sv
      - design/apb_requester.sv
      - design/mem_xfer_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - verification/tb_mem_xfer.sv
